// File: sim.f
src/axil_adapter_pkg.sv
src/axi_burst_iter.sv
src/rd_tag_fifo.sv
src/axil_rd_reflect.sv
src/axi_axil_adapter_rd.sv
test/adapter_chk.sv
test/adapter_scoreboard.sv
test/tb_axi_axil_adapter_rd.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_axi_axil_adapter_rd
RTL_TOP    ?= axi_axil_adapter_rd
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
SIM_ARGS   ?= +verilator+error+limit+1000
RTL_SRCS   ?= src/axil_adapter_pkg.sv src/axi_burst_iter.sv src/rd_tag_fifo.sv \
              src/axil_rd_reflect.sv src/axi_axil_adapter_rd.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -F -q "*** TEST FAILED ***" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -F -q "*** TEST PASSED ***" $(LOG) || (echo "No verdict in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_axi_axil_adapter_rd.sv
`timescale 1ns/1ps

module tb_axi_axil_adapter_rd
  import axil_adapter_pkg::*;
();

  localparam int N_TESTS = 10;

  typedef logic [95:0] name_t;

  typedef struct packed {
    name_t  name;
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    logic   rready_stall;
    logic   mem_stall;
  } test_row_t;

  logic   clk = 1'b0;
  logic   i_rst = 1'b1;
  logic   i_s_axi_arvalid = 1'b0;
  id_t    i_s_axi_arid = '0;
  addr_t  i_s_axi_araddr = '0;
  len_t   i_s_axi_arlen = '0;
  size_t  i_s_axi_arsize = '0;
  burst_t i_s_axi_arburst = '0;
  logic   i_s_axi_rready = 1'b0;
  logic   i_m_axil_arready = 1'b0;
  logic   i_m_axil_rvalid = 1'b0;
  data_t  i_m_axil_rdata = '0;
  resp_t  i_m_axil_rresp = '0;

  logic   o_s_axi_arready;
  logic   o_s_axi_rvalid;
  id_t    o_s_axi_rid;
  data_t  o_s_axi_rdata;
  resp_t  o_s_axi_rresp;
  logic   o_s_axi_rlast;
  logic   o_m_axil_arvalid;
  addr_t  o_m_axil_araddr;
  logic   o_m_axil_rready;

  test_row_t   tests [N_TESTS];
  name_t       cur_name = '0;
  logic        rstall_en = 1'b0;
  logic        mstall_en = 1'b0;
  logic [31:0] lfsr_state = 32'h78fc;
  addr_t       mem_q [$];
  int          cycles = 0;
  int          cycle_limit = 0;
  int          sb_done;
  int          sb_failed;
  int          sb_errors;

  function automatic test_row_t make_row(input name_t name, input id_t id, input addr_t addr,
                                         input len_t len, input size_t size,
                                         input burst_t burst, input logic rs, input logic ms);
    test_row_t r;
    r.name         = name;
    r.id           = id;
    r.addr         = addr;
    r.len          = len;
    r.size         = size;
    r.burst        = burst;
    r.rready_stall = rs;
    r.mem_stall    = ms;
    return r;
  endfunction

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_stall_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  initial begin
    forever #10 clk = ~clk;
  end

  axi_axil_adapter_rd i_dut (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_s_axi_arvalid  (i_s_axi_arvalid),
    .i_s_axi_arid     (i_s_axi_arid),
    .i_s_axi_araddr   (i_s_axi_araddr),
    .i_s_axi_arlen    (i_s_axi_arlen),
    .i_s_axi_arsize   (i_s_axi_arsize),
    .i_s_axi_arburst  (i_s_axi_arburst),
    .o_s_axi_arready  (o_s_axi_arready),
    .o_s_axi_rvalid   (o_s_axi_rvalid),
    .o_s_axi_rid      (o_s_axi_rid),
    .o_s_axi_rdata    (o_s_axi_rdata),
    .o_s_axi_rresp    (o_s_axi_rresp),
    .o_s_axi_rlast    (o_s_axi_rlast),
    .i_s_axi_rready   (i_s_axi_rready),
    .o_m_axil_arvalid (o_m_axil_arvalid),
    .o_m_axil_araddr  (o_m_axil_araddr),
    .i_m_axil_arready (i_m_axil_arready),
    .i_m_axil_rvalid  (i_m_axil_rvalid),
    .i_m_axil_rdata   (i_m_axil_rdata),
    .i_m_axil_rresp   (i_m_axil_rresp),
    .o_m_axil_rready  (o_m_axil_rready)
  );

  adapter_scoreboard u_sb (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_test_name    (cur_name),
    .i_arvalid      (i_s_axi_arvalid),
    .i_arready      (o_s_axi_arready),
    .i_arid         (i_s_axi_arid),
    .i_araddr       (i_s_axi_araddr),
    .i_arlen        (i_s_axi_arlen),
    .i_arsize       (i_s_axi_arsize),
    .i_arburst      (i_s_axi_arburst),
    .i_axil_arvalid (o_m_axil_arvalid),
    .i_rvalid       (o_s_axi_rvalid),
    .i_rready       (i_s_axi_rready),
    .i_rid          (o_s_axi_rid),
    .i_rdata        (o_s_axi_rdata),
    .i_rresp        (o_s_axi_rresp),
    .i_rlast        (o_s_axi_rlast),
    .o_tests_done   (sb_done),
    .o_tests_failed (sb_failed),
    .o_errors       (sb_errors)
  );

  // AXI-Lite memory, in order, at most one response per cycle
  always @(posedge clk) begin
    logic  take;
    addr_t head;
    if (i_rst) begin
      mem_q.delete();
      i_m_axil_arready <= 1'b0;
      i_m_axil_rvalid  <= 1'b0;
      i_s_axi_rready   <= 1'b0;
    end else begin
      if (i_m_axil_rvalid && o_m_axil_rready) begin
        void'(mem_q.pop_front());
      end
      if (o_m_axil_arvalid && i_m_axil_arready) begin
        mem_q.push_back(o_m_axil_araddr);
      end
      take = 1'b1;
      if (mstall_en) begin
        next_stall_bit(take);
      end
      i_m_axil_arready <= take;
      // Response held until the adapter takes it
      if (!(i_m_axil_rvalid && !o_m_axil_rready)) begin
        take = 1'b1;
        if (mstall_en) begin
          next_stall_bit(take);
        end
        if (mem_q.size() != 0 && take) begin
          head = mem_q[0];
          i_m_axil_rvalid <= 1'b1;
          i_m_axil_rdata  <= {16'h0000, head} ^ 32'h5a5a0000;
          i_m_axil_rresp  <= head[15] ? RESP_SLVERR : RESP_OKAY;
        end else begin
          i_m_axil_rvalid <= 1'b0;
        end
      end
      take = 1'b1;
      if (rstall_en) begin
        next_stall_bit(take);
      end
      i_s_axi_rready <= take;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    int total_beats;
    total_beats = 0;
    tests[0] = make_row(name_t'("incr8_id5"), 4'd5, 16'h0040, 8'd7, 3'd2, BURST_INCR, 0, 0);
    tests[1] = make_row(name_t'("fixed4"), 4'd3, 16'h0200, 8'd3, 3'd2, BURST_FIXED, 0, 0);
    tests[2] = make_row(name_t'("wrap4_0108"), 4'd1, 16'h0108, 8'd3, 3'd2, BURST_WRAP, 0, 0);
    tests[3] = make_row(name_t'("slverr_7ff8"), 4'd9, 16'h7ff8, 8'd5, 3'd2, BURST_INCR, 0, 0);
    tests[4] = make_row(name_t'("rnd_incr16"), 4'd2, 16'h1000, 8'd15, 3'd2, BURST_INCR, 1, 1);
    tests[5] = make_row(name_t'("rnd_wrap8"), 4'd7, 16'h2034, 8'd7, 3'd2, BURST_WRAP, 1, 1);
    tests[6] = make_row(name_t'("rnd_incr32"), 4'd12, 16'h3002, 8'd31, 3'd1, BURST_INCR, 1, 1);
    tests[7] = make_row(name_t'("rnd_wrap16"), 4'd14, 16'h4010, 8'd15, 3'd2, BURST_WRAP, 1, 1);
    tests[8] = make_row(name_t'("rstall_wrap2"), 4'd4, 16'h8006, 8'd1, 3'd1, BURST_WRAP, 1, 0);
    tests[9] = make_row(name_t'("mstall_256"), 4'd6, 16'h5000, 8'd255, 3'd0, BURST_INCR, 0, 1);
    for (int t = 0; t < N_TESTS; t++) begin
      total_beats += int'(tests[t].len) + 1;
    end
    cycle_limit = 20 * total_beats + 100;

    repeat (8) @(posedge clk);
    i_rst <= 1'b0;
    repeat (3) @(posedge clk);

    for (int t = 0; t < N_TESTS; t++) begin
      cur_name        <= tests[t].name;
      rstall_en       <= tests[t].rready_stall;
      mstall_en       <= tests[t].mem_stall;
      i_s_axi_arvalid <= 1'b1;
      i_s_axi_arid    <= tests[t].id;
      i_s_axi_araddr  <= tests[t].addr;
      i_s_axi_arlen   <= tests[t].len;
      i_s_axi_arsize  <= tests[t].size;
      i_s_axi_arburst <= tests[t].burst;
      do @(posedge clk); while (!o_s_axi_arready);
      i_s_axi_arvalid <= 1'b0;
      // Burst ends with the rlast beat
      do @(posedge clk); while (!(o_s_axi_rvalid && i_s_axi_rready && o_s_axi_rlast));
    end

    repeat (5) @(posedge clk);
    $display("Summary: %0d of %0d tests run, %0d failed, %0d errors, %0d assertion failures",
             sb_done, N_TESTS, sb_failed, sb_errors, i_dut.u_reflect.u_chk.fail_count);
    if (sb_done == N_TESTS && sb_failed == 0 && sb_errors == 0 &&
        i_dut.u_reflect.u_chk.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: test/adapter_scoreboard.sv
`timescale 1ns/1ps

module adapter_scoreboard
  import axil_adapter_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst,
  input  logic [95:0] i_test_name,
  input  logic        i_arvalid,
  input  logic        i_arready,
  input  id_t         i_arid,
  input  addr_t       i_araddr,
  input  len_t        i_arlen,
  input  size_t       i_arsize,
  input  burst_t      i_arburst,
  input  logic        i_axil_arvalid,
  input  logic        i_rvalid,
  input  logic        i_rready,
  input  id_t         i_rid,
  input  data_t       i_rdata,
  input  resp_t       i_rresp,
  input  logic        i_rlast,
  output int          o_tests_done,
  output int          o_tests_failed,
  output int          o_errors
);

  // Expected beats in arrival order
  addr_t exp_addr_q [$];
  id_t   exp_id_q [$];
  logic  exp_last_q [$];

  logic [95:0] cur_name = '0;
  logic        rst_q = 1'b0;
  int          tests_done = 0;
  int          tests_failed = 0;
  int          errors = 0;
  int          test_errs = 0;
  int          beat_num = 0;

  assign o_tests_done   = tests_done;
  assign o_tests_failed = tests_failed;
  assign o_errors       = errors;

  function automatic addr_t predict_addr(input addr_t start, input len_t len,
                                         input size_t size, input burst_t burst,
                                         input int unsigned k);
    int unsigned step;
    int unsigned start32;
    int unsigned window;
    int unsigned base;
    int unsigned result;
    step    = 32'd1 << size;
    start32 = 32'(start);
    window  = (32'(len) + 32'd1) * step;
    base    = start32 - (start32 % window);
    case (burst)
      BURST_FIXED: result = start32;
      // Offset runs around inside the aligned window
      BURST_WRAP:  result = base + ((start32 - base + k * step) % window);
      default:     result = start32 + k * step;
    endcase
    return addr_t'(result);
  endfunction

  task automatic queue_burst();
    for (int k = 0; k <= int'(i_arlen); k++) begin
      exp_addr_q.push_back(predict_addr(i_araddr, i_arlen, i_arsize, i_arburst, k));
      exp_id_q.push_back(i_arid);
      exp_last_q.push_back(k == int'(i_arlen));
    end
    cur_name = i_test_name;
  endtask

  task automatic compare_field(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Fail %0s beat %0d %0s: expected %h, actual %h",
               cur_name, beat_num, field, exp_v, act_v);
      test_errs++;
      errors++;
    end
  endtask

  task automatic check_beat();
    addr_t a;
    id_t   exp_id;
    logic  exp_last;
    if (exp_addr_q.size() == 0) begin
      $display("Error: R beat with ID %h arrived while no burst was outstanding", i_rid);
      errors++;
    end else begin
      a        = exp_addr_q.pop_front();
      exp_id   = exp_id_q.pop_front();
      exp_last = exp_last_q.pop_front();
      compare_field("rid", 32'(exp_id), 32'(i_rid));
      // Memory returns the address folded with a fixed pattern
      compare_field("rdata", {16'h0000, a} ^ 32'h5a5a0000, i_rdata);
      compare_field("rresp", 32'(a[15] ? RESP_SLVERR : RESP_OKAY), 32'(i_rresp));
      compare_field("rlast", 32'(exp_last), 32'(i_rlast));
      beat_num++;
      if (exp_last) begin
        tests_done++;
        if (test_errs == 0) begin
          $display("Test %0s: %0d beats ok", cur_name, beat_num);
        end else begin
          tests_failed++;
          $display("Test %0s: %0d beats, %0d mismatches", cur_name, beat_num, test_errs);
        end
        test_errs = 0;
        beat_num  = 0;
      end
    end
  endtask

  always @(posedge clk) begin
    rst_q <= i_rst;
    if (rst_q && !i_rst) begin
      if (!i_arready || i_axil_arvalid || i_rvalid) begin
        $display("Error: adapter not idle after reset (arready %b, arvalid %b, rvalid %b)",
                 i_arready, i_axil_arvalid, i_rvalid);
        errors++;
      end
    end
    if (!i_rst && i_arvalid && i_arready) begin
      queue_burst();
    end
    if (!i_rst && i_rvalid && i_rready) begin
      check_beat();
    end
  end

endmodule

// File: test/adapter_chk.sv
`timescale 1ns/1ps

module adapter_chk
  import axil_adapter_pkg::*;
(
  input logic  clk,
  input logic  i_rst,
  input logic  i_beat_valid,
  input addr_t i_beat_addr,
  input id_t   i_beat_id,
  input logic  i_beat_ready,
  input logic  i_axil_arvalid,
  input addr_t i_axil_araddr,
  input logic  i_axil_arready,
  input logic  i_rvalid,
  input logic  i_rready,
  input logic  i_tag_push,
  input logic  i_tag_pop
);

  int unsigned fail_count = 0;

  // Reads in flight as seen on the two buses
  int          in_flight = 0;

  always @(posedge clk) begin
    if (i_rst) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(i_axil_arvalid && i_axil_arready)
                             - int'(i_rvalid && i_rready);
    end
  end

  // Beat channel holds valid and payload until taken
  beat_stable: assert property (@(posedge clk) disable iff (i_rst)
    i_beat_valid && !i_beat_ready |=>
      i_beat_valid && $stable(i_beat_addr) && $stable(i_beat_id))
    else begin
      $error("beat channel changed before ready");
      fail_count++;
    end

  axil_ar_stable: assert property (@(posedge clk) disable iff (i_rst)
    i_axil_arvalid && !i_axil_arready |=> i_axil_arvalid && $stable(i_axil_araddr))
    else begin
      $error("AXI-Lite AR changed before ready");
      fail_count++;
    end

  no_pop_empty: assert property (@(posedge clk) disable iff (i_rst)
    i_tag_pop |-> in_flight > 0)
    else begin
      $error("tag pop with no read outstanding");
      fail_count++;
    end

  no_push_full: assert property (@(posedge clk) disable iff (i_rst)
    i_tag_push |-> in_flight < TAG_DEPTH)
    else begin
      $error("tag push while FIFO full");
      fail_count++;
    end

  // First cycle out of reset is quiet
  idle_after_reset: assert property (@(posedge clk)
    $fell(i_rst) |-> !i_axil_arvalid && !i_rvalid)
    else begin
      $error("valid high in the cycle after reset");
      fail_count++;
    end

endmodule

bind axil_rd_reflect adapter_chk u_chk (
  .clk            (clk),
  .i_rst          (i_rst),
  .i_beat_valid   (i_beat_valid),
  .i_beat_addr    (i_beat_addr),
  .i_beat_id      (i_beat_id),
  .i_beat_ready   (o_beat_ready),
  .i_axil_arvalid (o_m_axil_arvalid),
  .i_axil_araddr  (o_m_axil_araddr),
  .i_axil_arready (i_m_axil_arready),
  .i_rvalid       (o_s_axi_rvalid),
  .i_rready       (i_s_axi_rready),
  .i_tag_push     (o_tag_push),
  .i_tag_pop      (o_tag_pop)
);

// File: src/axi_axil_adapter_rd.sv
`timescale 1ns/1ps

module axi_axil_adapter_rd
  import axil_adapter_pkg::*;
(
  input  logic   clk,
  input  logic   i_rst,
  input  logic   i_s_axi_arvalid,
  input  id_t    i_s_axi_arid,
  input  addr_t  i_s_axi_araddr,
  input  len_t   i_s_axi_arlen,
  input  size_t  i_s_axi_arsize,
  input  burst_t i_s_axi_arburst,
  output logic   o_s_axi_arready,
  output logic   o_s_axi_rvalid,
  output id_t    o_s_axi_rid,
  output data_t  o_s_axi_rdata,
  output resp_t  o_s_axi_rresp,
  output logic   o_s_axi_rlast,
  input  logic   i_s_axi_rready,
  output logic   o_m_axil_arvalid,
  output addr_t  o_m_axil_araddr,
  input  logic   i_m_axil_arready,
  input  logic   i_m_axil_rvalid,
  input  data_t  i_m_axil_rdata,
  input  resp_t  i_m_axil_rresp,
  output logic   o_m_axil_rready
);

  // Beat channel
  logic  beat_valid;
  addr_t beat_addr;
  id_t   beat_id;
  logic  beat_last;
  logic  beat_ready;

  // Tag channel
  logic  tag_push;
  id_t   tag_push_id;
  logic  tag_push_last;
  logic  tag_pop;
  logic  tag_full;
  id_t   tag_pop_id;
  logic  tag_pop_last;

  axi_burst_iter u_iter (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_s_arvalid (i_s_axi_arvalid),
    .i_s_arid    (i_s_axi_arid),
    .i_s_araddr  (i_s_axi_araddr),
    .i_s_arlen   (i_s_axi_arlen),
    .i_s_arsize  (i_s_axi_arsize),
    .i_s_arburst (i_s_axi_arburst),
    .o_s_arready (o_s_axi_arready),
    .o_m_valid   (beat_valid),
    .o_m_addr    (beat_addr),
    .o_m_id      (beat_id),
    .o_m_last    (beat_last),
    .i_m_ready   (beat_ready)
  );

  rd_tag_fifo u_tags (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_push      (tag_push),
    .i_push_id   (tag_push_id),
    .i_push_last (tag_push_last),
    .i_pop       (tag_pop),
    .o_full      (tag_full),
    .o_empty     (),
    .o_head_id   (tag_pop_id),
    .o_head_last (tag_pop_last)
  );

  axil_rd_reflect u_reflect (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_beat_valid     (beat_valid),
    .i_beat_addr      (beat_addr),
    .i_beat_id        (beat_id),
    .i_beat_last      (beat_last),
    .o_beat_ready     (beat_ready),
    .o_tag_push       (tag_push),
    .o_tag_push_id    (tag_push_id),
    .o_tag_push_last  (tag_push_last),
    .o_tag_pop        (tag_pop),
    .i_tag_full       (tag_full),
    .i_tag_head_id    (tag_pop_id),
    .i_tag_head_last  (tag_pop_last),
    .o_m_axil_arvalid (o_m_axil_arvalid),
    .o_m_axil_araddr  (o_m_axil_araddr),
    .i_m_axil_arready (i_m_axil_arready),
    .i_m_axil_rvalid  (i_m_axil_rvalid),
    .i_m_axil_rdata   (i_m_axil_rdata),
    .i_m_axil_rresp   (i_m_axil_rresp),
    .o_m_axil_rready  (o_m_axil_rready),
    .o_s_axi_rvalid   (o_s_axi_rvalid),
    .o_s_axi_rid      (o_s_axi_rid),
    .o_s_axi_rdata    (o_s_axi_rdata),
    .o_s_axi_rresp    (o_s_axi_rresp),
    .o_s_axi_rlast    (o_s_axi_rlast),
    .i_s_axi_rready   (i_s_axi_rready)
  );

endmodule

// File: src/axil_rd_reflect.sv
`timescale 1ns/1ps

module axil_rd_reflect
  import axil_adapter_pkg::*;
(
  input  logic  clk,
  input  logic  i_rst,
  input  logic  i_beat_valid,
  input  addr_t i_beat_addr,
  input  id_t   i_beat_id,
  input  logic  i_beat_last,
  output logic  o_beat_ready,
  output logic  o_tag_push,
  output id_t   o_tag_push_id,
  output logic  o_tag_push_last,
  output logic  o_tag_pop,
  input  logic  i_tag_full,
  input  id_t   i_tag_head_id,
  input  logic  i_tag_head_last,
  output logic  o_m_axil_arvalid,
  output addr_t o_m_axil_araddr,
  input  logic  i_m_axil_arready,
  input  logic  i_m_axil_rvalid,
  input  data_t i_m_axil_rdata,
  input  resp_t i_m_axil_rresp,
  output logic  o_m_axil_rready,
  output logic  o_s_axi_rvalid,
  output id_t   o_s_axi_rid,
  output data_t o_s_axi_rdata,
  output resp_t o_s_axi_rresp,
  output logic  o_s_axi_rlast,
  input  logic  i_s_axi_rready
);

  localparam int CNT_W = $clog2(TAG_DEPTH + 1);

  logic [CNT_W-1:0] outstanding;
  logic             rd_active;

  // Address side, issue only while a tag slot is free
  assign o_m_axil_arvalid = i_beat_valid && !i_tag_full;
  assign o_m_axil_araddr  = i_beat_addr;
  assign o_beat_ready     = i_m_axil_arready && !i_tag_full;

  assign o_tag_push      = o_m_axil_arvalid && i_m_axil_arready;
  assign o_tag_push_id   = i_beat_id;
  assign o_tag_push_last = i_beat_last;

  // Nothing can return before a read was issued
  assign rd_active = (outstanding != '0);

  // Data side, straight through with the tag at the FIFO head
  assign o_s_axi_rvalid  = i_m_axil_rvalid && rd_active;
  assign o_m_axil_rready = i_s_axi_rready && rd_active;
  assign o_s_axi_rid     = i_tag_head_id;
  assign o_s_axi_rlast   = i_tag_head_last;
  assign o_s_axi_rdata   = i_m_axil_rdata;
  assign o_s_axi_rresp   = i_m_axil_rresp;

  assign o_tag_pop = o_s_axi_rvalid && i_s_axi_rready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      outstanding <= '0;
    end else if (o_tag_push && !o_tag_pop) begin
      outstanding <= outstanding + 1'b1;
    end else if (o_tag_pop && !o_tag_push) begin
      outstanding <= outstanding - 1'b1;
    end
  end

endmodule

// File: src/rd_tag_fifo.sv
`timescale 1ns/1ps

module rd_tag_fifo
  import axil_adapter_pkg::*;
(
  input  logic clk,
  input  logic i_rst,
  input  logic i_push,
  input  id_t  i_push_id,
  input  logic i_push_last,
  input  logic i_pop,
  output logic o_full,
  output logic o_empty,
  output id_t  o_head_id,
  output logic o_head_last
);

  localparam int PTR_W = $clog2(TAG_DEPTH);
  localparam int CNT_W = $clog2(TAG_DEPTH + 1);

  // Tag storage, one entry per outstanding read
  id_t  id_mem   [TAG_DEPTH];
  logic last_mem [TAG_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push_ok;
  logic pop_ok;

  assign push_ok = i_push && !o_full;
  assign pop_ok  = i_pop && !o_empty;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push_ok && !pop_ok) begin
        count <= count + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      id_mem[wr_ptr]   <= i_push_id;
      last_mem[wr_ptr] <= i_push_last;
    end
  end

  assign o_full      = (count == CNT_W'(TAG_DEPTH));
  assign o_empty     = (count == '0);
  assign o_head_id   = id_mem[rd_ptr];
  assign o_head_last = last_mem[rd_ptr];

endmodule

// File: src/axi_burst_iter.sv
`timescale 1ns/1ps

module axi_burst_iter
  import axil_adapter_pkg::*;
(
  input  logic   clk,
  input  logic   i_rst,
  input  logic   i_s_arvalid,
  input  id_t    i_s_arid,
  input  addr_t  i_s_araddr,
  input  len_t   i_s_arlen,
  input  size_t  i_s_arsize,
  input  burst_t i_s_arburst,
  output logic   o_s_arready,
  output logic   o_m_valid,
  output addr_t  o_m_addr,
  output id_t    o_m_id,
  output logic   o_m_last,
  input  logic   i_m_ready
);

  typedef enum logic [0:0] {
    IDLE,
    BURST
  } iter_state_t;

  iter_state_t state;

  // Accepted burst
  addr_t  addr_q;
  addr_t  step_q;
  addr_t  wrap_mask_q;
  id_t    id_q;
  burst_t burst_q;
  len_t   beats_left;

  // Decoded from the incoming request
  addr_t  ar_step;
  addr_t  ar_window;

  addr_t  incr_addr;
  addr_t  next_addr;

  logic   ar_xfer;
  logic   beat_xfer;

  assign ar_xfer   = i_s_arvalid && o_s_arready;
  assign beat_xfer = o_m_valid && i_m_ready;

  // Wrap window is (len + 1) beats of step bytes
  assign ar_step   = addr_t'(1) << i_s_arsize;
  assign ar_window = (addr_t'(i_s_arlen) + addr_t'(1)) << i_s_arsize;

  assign incr_addr = addr_q + step_q;

  always_comb begin
    case (burst_q)
      BURST_FIXED: next_addr = addr_q;
      BURST_WRAP:  next_addr = (addr_q & ~wrap_mask_q) | (incr_addr & wrap_mask_q);
      default:     next_addr = incr_addr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state      <= IDLE;
      beats_left <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (ar_xfer) begin
            state      <= BURST;
            beats_left <= i_s_arlen;
          end
        end
        BURST: begin
          if (beat_xfer) begin
            if (o_m_last) begin
              state <= IDLE;
            end else begin
              beats_left <= beats_left - 8'd1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Payload registers, loaded on accept and stepped per beat
  always_ff @(posedge clk) begin
    if (ar_xfer) begin
      addr_q      <= i_s_araddr;
      step_q      <= ar_step;
      wrap_mask_q <= ar_window - addr_t'(1);
      id_q        <= i_s_arid;
      burst_q     <= i_s_arburst;
    end else if (beat_xfer) begin
      addr_q <= next_addr;
    end
  end

  assign o_s_arready = (state == IDLE);
  assign o_m_valid   = (state == BURST);
  assign o_m_addr    = addr_q;
  assign o_m_id      = id_q;
  assign o_m_last    = (beats_left == '0);

endmodule

// File: src/axil_adapter_pkg.sv
package axil_adapter_pkg;

  // Bus geometry, same on both sides of the adapter
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int ID_W = 4;

  // Reads allowed in flight on the AXI-Lite side
  localparam int TAG_DEPTH = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ID_W-1:0] id_t;

  // Beats minus one
  typedef logic [7:0] len_t;

  // log2 of bytes per beat
  typedef logic [2:0] size_t;

  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  // AXI burst encodings
  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR = 2'd1;
  localparam burst_t BURST_WRAP = 2'd2;

  // Response codes used by the memory side
  localparam resp_t RESP_OKAY = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

endpackage
